// File: Bender.yml
package:
  name: adc_ctrl

sources:
  - logic/adc_pkg.sv
  - logic/adc_apb_regs.sv
  - logic/adc_conv_sequencer.sv
  - logic/adc_serial_reader.sv
  - logic/adc_sample_store.sv
  - logic/adc_ctrl_top.sv
  - target: test
    files:
      - testbench/adc_model.sv
      - testbench/adc_ctrl_sva.sv
      - testbench/adc_ctrl_tb.sv

// File: logic/adc_apb_regs.sv
`timescale 1ns/10ps

module adc_apb_regs #(
	parameter int N_CHAN = 8                            // number of readable data registers
) (
	input  logic                                   clk_in,
	input  logic                                   reset_in,
	input  adc_pkg::apb_req_t                      apb_req,
	output adc_pkg::apb_rsp_t                      apb_rsp,
	output logic                                   run,
	output logic [2:0]                             os_code,
	output logic [2:0]                             rd_chan,
	input  logic signed [adc_pkg::SAMPLE_W-1:0]    rd_data,
	input  logic [15:0]                            frame_count
);

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	logic       access;                                 // apb access phase
	logic       is_ctrl;
	logic       is_status;
	logic       is_data;
	logic [7:0] data_off;                               // offset from data base
	logic [2:0] wr_os;                                  // os field of write data
	logic [2:0] os_clamped;

	assign access    = apb_req.psel & apb_req.penable;
	assign is_ctrl   = (apb_req.paddr == adc_pkg::REG_CTRL);
	assign is_status = (apb_req.paddr == adc_pkg::REG_STATUS);
	assign data_off  = apb_req.paddr - adc_pkg::REG_DATA_BASE;
	assign is_data   = (apb_req.paddr >= adc_pkg::REG_DATA_BASE) &&
		(data_off < 8'(4 * N_CHAN)) && (apb_req.paddr[1:0] == 2'b00);   // word aligned only
	assign rd_chan   = data_off[4:2];                   // channel index into the store

	assign wr_os      = apb_req.pwdata[3:1];
	assign os_clamped = (wr_os < adc_pkg::OS_MIN) ? adc_pkg::OS_MIN : wr_os;   // never below min

	////////////////////////////////////////////////////////////
	// control register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			run     <= 1'b0;
			os_code <= adc_pkg::OS_MIN;
		end else if (access && apb_req.pwrite && is_ctrl) begin   // commit at end of access
			run     <= apb_req.pwdata[0];
			os_code <= os_clamped;
		end
	end

	////////////////////////////////////////////////////////////
	// read mux and response
	////////////////////////////////////////////////////////////

	always_comb begin
		apb_rsp.pready  = 1'b1;                         // no wait states
		apb_rsp.pslverr = 1'b0;
		apb_rsp.prdata  = '0;
		if (access) begin
			if (!(is_ctrl || is_status || is_data)) begin
				apb_rsp.pslverr = 1'b1;                 // unmapped offset
			end else if (apb_req.pwrite && !is_ctrl) begin
				apb_rsp.pslverr = 1'b1;                 // status and data are read only
			end else if (is_ctrl) begin
				apb_rsp.prdata = {28'd0, os_code, run};
			end else if (is_status) begin
				apb_rsp.prdata = {16'd0, frame_count};
			end else begin
				apb_rsp.prdata = {{(32 - adc_pkg::SAMPLE_W){rd_data[adc_pkg::SAMPLE_W-1]}},
					rd_data};                           // sign extend to bus width
			end
		end
	end

endmodule

// File: logic/adc_conv_sequencer.sv
`timescale 1ns/10ps

module adc_conv_sequencer #(
	parameter int MIN_T_CYCLE = 85                      // min cycles between convert starts
) (
	input  logic clk_in,
	input  logic reset_in,
	input  logic run,
	input  logic busy,
	output logic convst_n
);

	localparam int CNT_W = $clog2(MIN_T_CYCLE + 1);

	typedef enum logic [1:0] {
		CV_IDLE,                                        // wait for run
		CV_CONVST,                                      // single cycle convert pulse
		CV_CONV                                         // wait out cycle time and busy
	} cv_state_t;

	cv_state_t        state;
	cv_state_t        state_nxt;
	logic [CNT_W-1:0] cnt;                              // cycles spent in current state
	logic             cycle_done;

	assign cycle_done = (cnt == CNT_W'(MIN_T_CYCLE)) && !busy;

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			CV_IDLE:   if (run) state_nxt = CV_CONVST;
			CV_CONVST: state_nxt = CV_CONV;
			CV_CONV: begin
				if (cycle_done) begin
					state_nxt = run ? CV_CONVST : CV_IDLE;   // finish cycle, then stop if run dropped
				end
			end
			default:   state_nxt = CV_IDLE;
		endcase
	end

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			state <= CV_IDLE;
			cnt   <= '0;
		end else begin
			state <= state_nxt;
			if (state != state_nxt) begin
				cnt <= '0;                              // restart on every transition
			end else if (cnt != CNT_W'(MIN_T_CYCLE)) begin
				cnt <= cnt + 1'b1;                      // saturate so long busy cannot wrap
			end
		end
	end

	assign convst_n = (state != CV_CONVST);             // low for exactly one cycle

endmodule

// File: logic/adc_ctrl_top.sv
`timescale 1ns/10ps

module adc_ctrl_top #(
	parameter int N_CHAN      = 8,                      // 4, 6 or 8
	parameter int MIN_T_CYCLE = 85,                     // 5 us at 17 MHz
	parameter int SCLK_DIV    = 2                       // even, 2 or more
) (
	input  logic               clk_in,
	input  logic               reset_in,
	input  adc_pkg::apb_req_t  apb_req,
	output adc_pkg::apb_rsp_t  apb_rsp,
	input  logic               busy,
	input  logic               dout_a,
	input  logic               dout_b,
	output adc_pkg::adc_pins_t adc_pins
);

	logic                                run;
	logic [2:0]                          os_code;
	logic [2:0]                          rd_chan;
	logic signed [adc_pkg::SAMPLE_W-1:0] rd_data;
	logic [15:0]                         frame_count;
	logic                                convst_n;
	logic                                sclk;
	logic                                cs_n;
	adc_pkg::sample_wr_t                 sample_wr;
	logic                                frame_done;

	////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////

	adc_apb_regs #(.N_CHAN(N_CHAN)) i_regs (
		.clk_in(clk_in), .reset_in(reset_in), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.run(run), .os_code(os_code), .rd_chan(rd_chan), .rd_data(rd_data),
		.frame_count(frame_count)
	);

	adc_conv_sequencer #(.MIN_T_CYCLE(MIN_T_CYCLE)) i_seq (
		.clk_in(clk_in), .reset_in(reset_in), .run(run), .busy(busy), .convst_n(convst_n)
	);

	adc_serial_reader #(.N_CHAN(N_CHAN), .SCLK_DIV(SCLK_DIV)) i_reader (
		.clk_in(clk_in), .reset_in(reset_in), .busy(busy), .dout_a(dout_a),
		.dout_b(dout_b), .sclk(sclk), .cs_n(cs_n), .sample_wr(sample_wr),
		.frame_done(frame_done)
	);

	adc_sample_store #(.N_CHAN(N_CHAN)) i_store (
		.clk_in(clk_in), .reset_in(reset_in), .sample_wr(sample_wr),
		.frame_done(frame_done), .rd_chan(rd_chan), .rd_data(rd_data),
		.frame_count(frame_count)
	);

	// converter pins
	assign adc_pins.os        = os_code;
	assign adc_pins.convst_n  = convst_n;
	assign adc_pins.adc_reset = reset_in;               // converter held in reset with us
	assign adc_pins.sclk      = sclk;
	assign adc_pins.cs_n      = cs_n;

endmodule

// File: logic/adc_pkg.sv
package adc_pkg;

	////////////////////////////////////////////////////////////
	// converter and register map constants
	////////////////////////////////////////////////////////////

	localparam int SAMPLE_W = 18;                       // ad7608 resolution
	localparam logic [2:0] OS_MIN = 3'd1;               // 2x oversampling minimum, 8 channels need it

	localparam logic [7:0] REG_CTRL      = 8'h00;       // run, os code
	localparam logic [7:0] REG_STATUS    = 8'h04;       // frame counter
	localparam logic [7:0] REG_DATA_BASE = 8'h10;       // channel c at base + 4*c

	////////////////////////////////////////////////////////////
	// shared structs
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0]  paddr;                             // byte offset
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic [2:0] os;                                 // oversampling pins
		logic       convst_n;                           // convert start, active low
		logic       adc_reset;                          // converter reset, active high
		logic       sclk;                               // serial bit clock
		logic       cs_n;                               // chip select, active low
	} adc_pins_t;

	typedef struct packed {
		logic                       valid;              // one write this cycle
		logic [2:0]                 chan;               // target channel
		logic signed [SAMPLE_W-1:0] data;               // raw two's complement word
	} sample_wr_t;

endpackage

// File: logic/adc_sample_store.sv
`timescale 1ns/10ps

module adc_sample_store #(
	parameter int N_CHAN = 8
) (
	input  logic                                clk_in,
	input  logic                                reset_in,
	input  adc_pkg::sample_wr_t                 sample_wr,
	input  logic                                frame_done,
	input  logic [2:0]                          rd_chan,
	output logic signed [adc_pkg::SAMPLE_W-1:0] rd_data,
	output logic [15:0]                         frame_count
);

	logic signed [adc_pkg::SAMPLE_W-1:0] samples [N_CHAN];   // latest word per channel

	////////////////////////////////////////////////////////////
	// sample registers and frame counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			for (int i = 0; i < N_CHAN; i++) begin
				samples[i] <= '0;                       // reads as zero before first frame
			end
			frame_count <= '0;
		end else begin
			if (sample_wr.valid) begin
				samples[sample_wr.chan] <= sample_wr.data;   // visible next cycle
			end
			if (frame_done) begin
				frame_count <= frame_count + 1'b1;      // wraps at 16 bits
			end
		end
	end

	// guard channels past N_CHAN when fewer are built
	assign rd_data = ({1'b0, rd_chan} < 4'(N_CHAN)) ? samples[rd_chan] : '0;

endmodule

// File: logic/adc_serial_reader.sv
`timescale 1ns/10ps

module adc_serial_reader #(
	parameter int N_CHAN   = 8,                         // even, half on each data line
	parameter int SCLK_DIV = 2                          // clk_in cycles per serial bit
) (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic                busy,
	input  logic                dout_a,
	input  logic                dout_b,
	output logic                sclk,
	output logic                cs_n,
	output adc_pkg::sample_wr_t sample_wr,
	output logic                frame_done
);

	localparam int SW     = adc_pkg::SAMPLE_W;
	localparam int N_HALF = N_CHAN / 2;                 // words per data line
	localparam int DIV_W  = (SCLK_DIV > 2) ? $clog2(SCLK_DIV) : 1;
	localparam int BIT_W  = $clog2(SW);
	localparam int WRD_W  = (N_HALF > 2) ? $clog2(N_HALF) : 1;

	typedef enum logic [1:0] {
		RD_IDLE,                                        // wait for busy to rise
		RD_READ,                                        // clock out both lines
		RD_WAIT                                         // wait for busy to fall
	} rd_state_t;

	rd_state_t        state;
	logic [DIV_W-1:0] div_cnt;                          // position inside bit period
	logic [BIT_W-1:0] bit_cnt;                          // bit inside word
	logic [WRD_W-1:0] word_cnt;                         // word position on each line
	logic [SW-1:0]    shift_a;
	logic [SW-1:0]    shift_b;
	logic [SW-1:0]    hold_b;                           // b word waiting for its write slot
	logic             pend_b;                           // b write due next cycle
	logic             last_b;                           // pending b word ends the frame
	logic             pend_done;
	logic             sample_tick;                      // sclk rising cycle
	logic             word_tick;                        // last bit of a word sampled
	logic             last_tick;                        // final cycle of the read

	assign sample_tick = (state == RD_READ) && (div_cnt == '0);
	assign word_tick   = sample_tick && (bit_cnt == BIT_W'(SW - 1));
	assign last_tick   = (state == RD_READ) && (div_cnt == DIV_W'(SCLK_DIV - 1)) &&
		(bit_cnt == BIT_W'(SW - 1)) && (word_cnt == WRD_W'(N_HALF - 1));

	assign cs_n = (state != RD_READ);
	assign sclk = (state == RD_READ) && (div_cnt < DIV_W'(SCLK_DIV / 2));   // high in first half

	////////////////////////////////////////////////////////////
	// state and bit counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			state    <= RD_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			word_cnt <= '0;
		end else begin
			case (state)
				RD_IDLE: if (busy) state <= RD_READ;    // read overlaps conversion
				RD_READ: if (last_tick) state <= RD_WAIT;
				RD_WAIT: if (!busy) state <= RD_IDLE;   // re-arm only after busy falls
				default: state <= RD_IDLE;
			endcase
			if (state != RD_READ) begin
				div_cnt  <= '0;
				bit_cnt  <= '0;
				word_cnt <= '0;
			end else if (div_cnt == DIV_W'(SCLK_DIV - 1)) begin
				div_cnt <= '0;
				if (bit_cnt == BIT_W'(SW - 1)) begin
					bit_cnt  <= '0;
					word_cnt <= word_cnt + 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (sample_tick) begin
			shift_a <= {shift_a[SW-2:0], dout_a};       // msb first
			shift_b <= {shift_b[SW-2:0], dout_b};
		end
		if (word_tick) begin
			hold_b <= {shift_b[SW-2:0], dout_b};
		end
	end

	////////////////////////////////////////////////////////////
	// store writes, a word then b word
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			sample_wr  <= '0;
			pend_b     <= 1'b0;
			last_b     <= 1'b0;
			pend_done  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			sample_wr.valid <= 1'b0;
			pend_b          <= word_tick;
			pend_done       <= pend_b && last_b;
			frame_done      <= pend_done;               // one cycle after last b write
			if (word_tick) begin
				sample_wr.valid <= 1'b1;
				sample_wr.chan  <= 3'(word_cnt);        // line a channel
				sample_wr.data  <= {shift_a[SW-2:0], dout_a};
				last_b          <= (word_cnt == WRD_W'(N_HALF - 1));
			end else if (pend_b) begin
				sample_wr.valid <= 1'b1;
				sample_wr.chan  <= sample_wr.chan + 3'(N_HALF);   // matching line b channel
				sample_wr.data  <= hold_b;
			end
		end
	end

endmodule

// File: sim.f
logic/adc_pkg.sv
logic/adc_apb_regs.sv
logic/adc_conv_sequencer.sv
logic/adc_serial_reader.sv
logic/adc_sample_store.sv
logic/adc_ctrl_top.sv
testbench/adc_model.sv
testbench/adc_ctrl_sva.sv
testbench/adc_ctrl_tb.sv

// File: testbench/adc_ctrl_sva.sv
`timescale 1ns/10ps

module adc_ctrl_sva (
	input logic               clk_in,
	input logic               reset_in,
	input logic               busy,
	input adc_pkg::adc_pins_t adc_pins
);

	// convert start is a single cycle pulse
	convst_single: assert property (@(posedge clk_in) disable iff (reset_in)
		!adc_pins.convst_n |=> adc_pins.convst_n)
		else $error("convst_n low for two cycles in a row");

	// a read only opens after busy was seen high
	cs_after_busy: assert property (@(posedge clk_in) disable iff (reset_in)
		$fell(adc_pins.cs_n) |-> $past(busy))
		else $error("cs_n fell without busy high");

	// bit clock quiet outside chip select
	sclk_quiet: assert property (@(posedge clk_in) disable iff (reset_in)
		adc_pins.cs_n |-> $stable(adc_pins.sclk))
		else $error("sclk toggled while cs_n high");

endmodule

bind adc_ctrl_top adc_ctrl_sva i_sva (
	.clk_in(clk_in), .reset_in(reset_in), .busy(busy), .adc_pins(adc_pins)
);

// File: testbench/adc_ctrl_tb.sv
`timescale 1ns/10ps

module adc_ctrl_tb;

	localparam int N_CHAN      = 8;
	localparam int MIN_T_CYCLE = 85;
	localparam int SCLK_DIV    = 2;
	localparam int SW          = adc_pkg::SAMPLE_W;

	logic                 clk_in = 1'b0;
	logic                 reset_in = 1'b1;
	adc_pkg::apb_req_t    apb_req = '0;
	adc_pkg::apb_rsp_t    apb_rsp;
	adc_pkg::adc_pins_t   adc_pins;
	logic                 busy;
	logic                 dout_a;
	logic                 dout_b;
	logic [7:0]           conv_idx;
	int                   conv_cycles = 180;
	logic [N_CHAN*SW-1:0] frame_tbl [256];              // converter input per conversion
	int                   pulses = 0;                   // convst pulses seen at the pins
	int                   cycle_no = 0;
	int                   last_pulse = -1000;
	int                   wd_cycles = 0;
	logic [31:0]          rng = 32'h8fba;
	logic [2:0]           os_exp = adc_pkg::OS_MIN;
	string                lines [$];

	always #10 clk_in = ~clk_in;

	adc_ctrl_top #(.N_CHAN(N_CHAN), .MIN_T_CYCLE(MIN_T_CYCLE), .SCLK_DIV(SCLK_DIV)) i_dut (
		.clk_in(clk_in), .reset_in(reset_in), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.busy(busy), .dout_a(dout_a), .dout_b(dout_b), .adc_pins(adc_pins)
	);

	adc_model #(.N_CHAN(N_CHAN)) i_model (
		.clk_in(clk_in), .reset_in(reset_in), .convst_n(adc_pins.convst_n),
		.sclk(adc_pins.sclk), .cs_n(adc_pins.cs_n), .conv_cycles(conv_cycles),
		.frame(frame_tbl[conv_idx]), .busy(busy), .dout_a(dout_a), .dout_b(dout_b),
		.conv_idx(conv_idx)
	);

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_sample(input string name, input logic [31:0] got,
		input logic signed [SW-1:0] exp);
		logic signed [31:0] exp_ext;
		exp_ext = exp;                                  // sign extension as seen on the bus
		if (got !== exp_ext)
			stop_with_failure($sformatf("[ERROR] %0t %s read %h, expected %h", $time, name,
				got, exp_ext));
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t %s read %h, expected %h", $time, name,
				got, exp));
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t %s pslverr %b, expected %b", $time, name,
				got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	////////////////////////////////////////////////////////////
	// apb master with setup and access phases
	////////////////////////////////////////////////////////////

	task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge clk_in);
		apb_req.paddr   = addr;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.pwdata  = wdata;
		@(negedge clk_in);
		apb_req.penable = 1'b1;
		#5;                                             // sampled mid access
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		check_word("pready", 32'(apb_rsp.pready), 32'd1);   // no wait states
		@(negedge clk_in);
		apb_req = '0;
	endtask

	task automatic wait_frames(input int target);
		logic [31:0] rd;
		logic        er;
		do begin
			apb_xfer(adc_pkg::REG_STATUS, 1'b0, '0, rd, er);
			if (rd[15:0] > 16'(target))
				stop_with_failure($sformatf("frame counter went past %0d unseen", target));
		end while (rd[15:0] != 16'(target));
	endtask

	// frame below zero means the store still holds its reset zeros
	task automatic check_regs(input int frame);
		logic [31:0] rd;
		logic        er;
		apb_xfer(adc_pkg::REG_CTRL, 1'b0, '0, rd, er);
		check_word("CTRL", rd, {28'd0, os_exp, 1'b0});
		apb_xfer(adc_pkg::REG_STATUS, 1'b0, '0, rd, er);
		check_word("STATUS", rd, 32'(pulses));
		for (int c = 0; c < N_CHAN; c++) begin
			apb_xfer(adc_pkg::REG_DATA_BASE + 8'(4*c), 1'b0, '0, rd, er);
			check_err($sformatf("DATA%0d", c), er, 1'b0);
			if (frame >= 0)
				check_sample($sformatf("DATA%0d", c), rd, frame_tbl[frame][c*SW +: SW]);
			else
				check_sample($sformatf("DATA%0d", c), rd, '0);
		end
	endtask

	task automatic run_burst(input int conv, input int n);
		logic [31:0] rd;
		logic        er;
		int          j0;
		j0          = pulses;
		conv_cycles = conv;
		apb_xfer(adc_pkg::REG_CTRL, 1'b1, {28'd0, os_exp, 1'b1}, rd, er);
		for (int k = 0; k < n; k++) begin
			wait_frames(j0 + k + 2);                    // frame j is read during conversion j+1
			for (int c = 0; c < N_CHAN; c++) begin
				apb_xfer(adc_pkg::REG_DATA_BASE + 8'(4*c), 1'b0, '0, rd, er);
				check_sample($sformatf("DATA%0d", c), rd, frame_tbl[j0 + k][c*SW +: SW]);
			end
		end
		apb_xfer(adc_pkg::REG_CTRL, 1'b1, {28'd0, os_exp, 1'b0}, rd, er);
		repeat (4) @(negedge clk_in);
		wait_frames(pulses);                            // one frame per conversion
		repeat (400) @(negedge clk_in);
		check_regs(pulses - 2);                         // counter stays put once idle
	endtask

	// convst spacing and busy overlap at the pins
	always @(negedge clk_in) begin
		cycle_no <= cycle_no + 1;
		if (!reset_in && !adc_pins.convst_n) begin
			if (busy)
				stop_with_failure($sformatf("[ERROR] %0t convst_n low while busy", $time));
			if (cycle_no - last_pulse < MIN_T_CYCLE + 1)
				stop_with_failure($sformatf("[ERROR] %0t convst spacing %0d cycles", $time,
					cycle_no - last_pulse));
			last_pulse <= cycle_no;
			pulses     <= pulses + 1;
		end
	end

	initial begin
		wait (wd_cycles != 0);
		repeat (wd_cycles) @(posedge clk_in);
		stop_with_failure("the run timed out before all tests finished");
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int          fd;
		int          frames;
		int          a;
		int          b;
		string       line;
		string       cmd;
		logic [31:0] v [8];
		logic [31:0] rd;
		logic        er;
		frames = 0;
		for (int i = 0; i < 256; i++)
			for (int c = 0; c < N_CHAN; c++)
				frame_tbl[i][c*SW +: SW] = SW'(i*4099 + c*771 + 5);
		fd = $fopen("testbench/adc_tests.txt", "r");
		if (fd == 0)
			stop_with_failure("could not open testbench/adc_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#")
				lines.push_back(line);
		end
		$fclose(fd);
		foreach (lines[i]) begin
			if ($sscanf(lines[i], "%s %d %d", cmd, a, b) == 3 && cmd == "rnd")
				frames += b;
		end
		wd_cycles = (lines.size() + frames + 1) * 4 * (MIN_T_CYCLE + 200);

		repeat (4) @(negedge clk_in);
		check_word("adc_reset pin", 32'(adc_pins.adc_reset), 32'd1);
		reset_in = 1'b0;
		check_word("convst_n pin", 32'(adc_pins.convst_n), 32'd1);
		check_word("cs_n pin", 32'(adc_pins.cs_n), 32'd1);
		check_word("sclk pin", 32'(adc_pins.sclk), 32'd0);
		check_regs(-1);
		check_word("adc_reset pin", 32'(adc_pins.adc_reset), 32'd0);   // follows reset_in

		foreach (lines[i]) begin
			void'($sscanf(lines[i], "%s", cmd));
			if (cmd == "os") begin
				void'($sscanf(lines[i], "%s %d", cmd, a));
				apb_xfer(adc_pkg::REG_CTRL, 1'b1, 32'(a[2:0]) << 1, rd, er);
				os_exp = (a[2:0] == 3'd0) ? 3'd1 : a[2:0];   // clamp to the minimum code
				check_regs(pulses - 2);
				check_word("os pins", 32'(adc_pins.os), 32'(os_exp));
			end else if (cmd == "fix") begin
				void'($sscanf(lines[i], "%s %d %h %h %h %h %h %h %h %h", cmd, a,
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]));
				for (int c = 0; c < N_CHAN; c++)
					frame_tbl[pulses][c*SW +: SW] = v[c][SW-1:0];
				run_burst(a, 1);
			end else if (cmd == "rnd") begin
				void'($sscanf(lines[i], "%s %d %d", cmd, a, b));
				for (int k = 0; k < b; k++)
					for (int c = 0; c < N_CHAN; c++) begin
						rng = xorshift(rng);
						frame_tbl[pulses + k][c*SW +: SW] = rng[SW-1:0];
					end
				run_burst(a, b);
			end else if (cmd == "err") begin
				void'($sscanf(lines[i], "%s %h %d", cmd, a, b));
				apb_xfer(a[7:0], b[0], 32'hffff_ffff, rd, er);
				check_err($sformatf("offset %h", a[7:0]), er, 1'b1);
				check_regs(pulses - 2);                 // nothing changed
			end else begin
				stop_with_failure($sformatf("unknown command in tests file: %s", lines[i]));
			end
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: testbench/adc_model.sv
`timescale 1ns/10ps

module adc_model #(
	parameter int N_CHAN = 8                            // even, half on each data line
) (
	input  logic                                clk_in,
	input  logic                                reset_in,
	input  logic                                convst_n,
	input  logic                                sclk,
	input  logic                                cs_n,
	input  int                                  conv_cycles,   // busy length in clk_in cycles
	input  logic [N_CHAN*adc_pkg::SAMPLE_W-1:0] frame,         // analog input of next conversion
	output logic                                busy,
	output logic                                dout_a,
	output logic                                dout_b,
	output logic [7:0]                          conv_idx       // conversions started so far
);

	localparam int SW     = adc_pkg::SAMPLE_W;
	localparam int N_HALF = N_CHAN / 2;

	logic [N_CHAN*SW-1:0] conv_val;                     // frame being converted
	logic [N_CHAN*SW-1:0] out_val;                      // last finished frame, read out serially
	int                   delay_cnt;
	int                   busy_cnt;
	int                   bit_idx;                      // bit position over the whole line

	////////////////////////////////////////////////////////////
	// conversion timing on falling clk_in
	////////////////////////////////////////////////////////////

	always @(negedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			busy      <= 1'b0;
			conv_idx  <= '0;
			conv_val  <= '0;
			out_val   <= '0;
			delay_cnt <= 0;
			busy_cnt  <= 0;
		end else if (!convst_n) begin
			conv_val  <= frame;                         // track and hold closes
			conv_idx  <= conv_idx + 1'b1;
			delay_cnt <= 3;
		end else if (delay_cnt != 0) begin
			delay_cnt <= delay_cnt - 1;
			if (delay_cnt == 1) begin
				busy     <= 1'b1;
				busy_cnt <= conv_cycles;
			end
		end else if (busy) begin
			busy_cnt <= busy_cnt - 1;
			if (busy_cnt == 1) begin
				busy    <= 1'b0;
				out_val <= conv_val;                    // results ready for the next read
			end
		end
	end

	////////////////////////////////////////////////////////////
	// msb first serial output
	////////////////////////////////////////////////////////////

	task automatic present_bit();
		int w;
		int b;
		w = bit_idx / SW;
		b = SW - 1 - (bit_idx % SW);
		if (w < N_HALF) begin
			dout_a = out_val[w*SW + b];
			dout_b = out_val[(w + N_HALF)*SW + b];
		end
	endtask

	initial begin
		busy   = 1'b0;
		dout_a = 1'b0;
		dout_b = 1'b0;
	end

	always @(negedge cs_n) begin
		bit_idx = 0;                                    // first bit ready before first rise
		present_bit();
	end

	always @(negedge sclk) begin
		if (!cs_n) begin
			bit_idx++;
			present_bit();
		end
	end

endmodule

// File: testbench/adc_tests.txt
# os <code> | fix <conv cycles> <ch0..ch7 hex> | rnd <conv cycles> <frames>
# err <offset hex> <write 0/1>
os 0
os 1
os 2
os 3
os 4
os 5
os 6
os 7
fix 180 1ffff 20000 00000 3ffff 00001 12345 2abcd 15a5a
fix 200 20000 1ffff 3ffff 00000 0aaaa 35555 00100 3ff00
rnd 180 4
rnd 220 3
err 08 0
err 08 1
err 04 1
err 10 1
err 30 0
err 11 0
os 0
